/* project.f */
hdl/cpu_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/regfile.sv
hdl/reg_ex1.sv
hdl/exc_ctrl.sv
hdl/issue_ex1_top.sv
verif/tb_issue_ex1.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --top-module tb_issue_ex1 -f project.f -o tb_issue_ex1 \
    && ./obj_dir/tb_issue_ex1 2>&1 | tee sim.log \
    || echo "build or simulation did not run" | tee sim.log
grep -q "^TEST PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verif/tb_issue_ex1.sv */
module tb_issue_ex1;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 2;
    localparam int READ_CYCLES  = 8;
    localparam int OPER_CYCLES  = 300;
    localparam int PIPE_CYCLES  = 200;
    localparam int FLUSH_CYCLES = 200;
    localparam int TRAP_CYCLES  = 300;
    localparam int TOTAL_CYCLES = RESET_CYCLES + READ_CYCLES + OPER_CYCLES + PIPE_CYCLES
                                + FLUSH_CYCLES + TRAP_CYCLES;
    localparam int TIME_LIMIT   = TOTAL_CYCLES * CLK_PERIOD + 20 * CLK_PERIOD;

    logic clk;
    logic rst_n;
    logic flush;
    logic redirect;

    // issue and writeback inputs per lane.
    logic                   valid [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::uop_t      uop [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::word_t     imm [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::reg_addr_t rj [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::reg_addr_t rk [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::reg_addr_t rd [pipe_pkg::NUM_LANES];
    logic                   sys [pipe_pkg::NUM_LANES];
    logic                   brk [pipe_pkg::NUM_LANES];
    logic                   priv [pipe_pkg::NUM_LANES];
    logic                   we [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::reg_addr_t waddr [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::word_t     wdata [pipe_pkg::NUM_LANES];

    // DUT outputs.
    logic                    o_valid [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::uop_t       o_uop [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::word_t      o_imm [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::reg_addr_t  o_rj [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::reg_addr_t  o_rk [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::reg_addr_t  o_rd [pipe_pkg::NUM_LANES];
    logic                    o_sys [pipe_pkg::NUM_LANES];
    logic                    o_brk [pipe_pkg::NUM_LANES];
    logic                    o_priv [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::word_t      o_rj_data [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::word_t      o_rk_data [pipe_pkg::NUM_LANES];
    logic                    o_trap_valid;
    cpu_isa_pkg::exc_cause_t o_trap_cause;
    logic                    o_trap_lane;
    logic                    o_kill_lane1;

    // reference model with register array, expected latch and exception FSM.
    cpu_isa_pkg::word_t      m_regs [cpu_isa_pkg::NUM_REGS];
    logic                    e_valid [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::uop_t       e_uop [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::word_t      e_imm [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::reg_addr_t  e_rj [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::reg_addr_t  e_rk [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::reg_addr_t  e_rd [pipe_pkg::NUM_LANES];
    logic                    e_sys [pipe_pkg::NUM_LANES];
    logic                    e_brk [pipe_pkg::NUM_LANES];
    logic                    e_priv [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::word_t      e_rj_data [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::word_t      e_rk_data [pipe_pkg::NUM_LANES];
    pipe_pkg::exc_state_t    m_state;
    cpu_isa_pkg::exc_cause_t m_cause;
    logic                    m_lane;

    int errors;
    int checks;
    int tests;
    int traps;

    issue_ex1_top dut_i (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .valid0_i       (valid[0]),
        .valid1_i       (valid[1]),
        .uop0_i         (uop[0]),
        .uop1_i         (uop[1]),
        .imm0_i         (imm[0]),
        .imm1_i         (imm[1]),
        .rj0_i          (rj[0]),
        .rk0_i          (rk[0]),
        .rd0_i          (rd[0]),
        .rj1_i          (rj[1]),
        .rk1_i          (rk[1]),
        .rd1_i          (rd[1]),
        .syscall0_i     (sys[0]),
        .brk0_i         (brk[0]),
        .priv0_i        (priv[0]),
        .syscall1_i     (sys[1]),
        .brk1_i         (brk[1]),
        .priv1_i        (priv[1]),
        .we0_i          (we[0]),
        .waddr0_i       (waddr[0]),
        .wdata0_i       (wdata[0]),
        .we1_i          (we[1]),
        .waddr1_i       (waddr[1]),
        .wdata1_i       (wdata[1]),
        .flush_i        (flush),
        .redirect_i     (redirect),
        .ex1_valid0_o   (o_valid[0]),
        .ex1_valid1_o   (o_valid[1]),
        .ex1_uop0_o     (o_uop[0]),
        .ex1_uop1_o     (o_uop[1]),
        .ex1_imm0_o     (o_imm[0]),
        .ex1_imm1_o     (o_imm[1]),
        .ex1_rj0_o      (o_rj[0]),
        .ex1_rk0_o      (o_rk[0]),
        .ex1_rd0_o      (o_rd[0]),
        .ex1_rj1_o      (o_rj[1]),
        .ex1_rk1_o      (o_rk[1]),
        .ex1_rd1_o      (o_rd[1]),
        .ex1_syscall0_o (o_sys[0]),
        .ex1_brk0_o     (o_brk[0]),
        .ex1_priv0_o    (o_priv[0]),
        .ex1_syscall1_o (o_sys[1]),
        .ex1_brk1_o     (o_brk[1]),
        .ex1_priv1_o    (o_priv[1]),
        .ex1_rj0_data_o (o_rj_data[0]),
        .ex1_rj1_data_o (o_rj_data[1]),
        .ex1_rk0_data_o (o_rk_data[0]),
        .ex1_rk1_data_o (o_rk_data[1]),
        .trap_valid_o   (o_trap_valid),
        .trap_cause_o   (o_trap_cause),
        .trap_lane_o    (o_trap_lane),
        .kill_lane1_o   (o_kill_lane1)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic clear_inputs();
        for (int l = 0; l < pipe_pkg::NUM_LANES; l++) begin
            valid[l] = 1'b0;
            uop[l]   = '0;
            imm[l]   = '0;
            rj[l]    = '0;
            rk[l]    = '0;
            rd[l]    = '0;
            sys[l]   = 1'b0;
            brk[l]   = 1'b0;
            priv[l]  = 1'b0;
            we[l]    = 1'b0;
            waddr[l] = '0;
            wdata[l] = '0;
        end
        flush    = 1'b0;
        redirect = 1'b0;
    endtask

    function automatic cpu_isa_pkg::word_t model_read(input cpu_isa_pkg::reg_addr_t a);
        if (a == '0) begin
            return '0;
        end
        // younger write port first.
        if (we[1] && (waddr[1] == a)) begin
            return wdata[1];
        end
        if (we[0] && (waddr[0] == a)) begin
            return wdata[0];
        end
        return m_regs[a];
    endfunction

    // advances the model by one rising edge with the inputs now driven.
    task automatic model_edge();
        cpu_isa_pkg::word_t      rj_val [pipe_pkg::NUM_LANES];
        cpu_isa_pkg::word_t      rk_val [pipe_pkg::NUM_LANES];
        cpu_isa_pkg::exc_cause_t cause;
        logic                    found;
        logic                    lane;
        logic                    clear;
        found = 1'b0;
        lane  = 1'b0;
        cause = cpu_isa_pkg::EXC_NONE;
        clear = flush || (m_state != pipe_pkg::ST_RUN);
        for (int l = 0; l < pipe_pkg::NUM_LANES; l++) begin
            rj_val[l] = model_read(rj[l]);
            rk_val[l] = model_read(rk[l]);
        end
        // oldest lane wins and syscall beats break beats privileged.
        for (int l = 0; l < pipe_pkg::NUM_LANES; l++) begin
            if (!found && e_valid[l] && (e_sys[l] || e_brk[l] || e_priv[l])) begin
                found = 1'b1;
                lane  = 1'(l);
                if (e_sys[l]) begin
                    cause = cpu_isa_pkg::EXC_SYSCALL;
                end else if (e_brk[l]) begin
                    cause = cpu_isa_pkg::EXC_BREAK;
                end else begin
                    cause = cpu_isa_pkg::EXC_PRIV;
                end
            end
        end
        case (m_state)
            pipe_pkg::ST_RUN: begin
                if (found) begin
                    m_state = pipe_pkg::ST_TRAP;
                    m_cause = cause;
                    m_lane  = lane;
                end
            end
            pipe_pkg::ST_TRAP: m_state = pipe_pkg::ST_DRAIN;
            default: begin
                if (redirect) begin
                    m_state = pipe_pkg::ST_RUN;
                end
            end
        endcase
        for (int l = 0; l < pipe_pkg::NUM_LANES; l++) begin
            e_valid[l]   = clear ? 1'b0 : valid[l];
            e_uop[l]     = clear ? '0 : uop[l];
            e_imm[l]     = clear ? '0 : imm[l];
            e_rj[l]      = clear ? '0 : rj[l];
            e_rk[l]      = clear ? '0 : rk[l];
            e_rd[l]      = clear ? '0 : rd[l];
            e_sys[l]     = clear ? 1'b0 : sys[l];
            e_brk[l]     = clear ? 1'b0 : brk[l];
            e_priv[l]    = clear ? 1'b0 : priv[l];
            e_rj_data[l] = clear ? '0 : rj_val[l];
            e_rk_data[l] = clear ? '0 : rk_val[l];
        end
        for (int p = 0; p < pipe_pkg::NUM_LANES; p++) begin
            if (we[p] && (waddr[p] != '0)) begin
                m_regs[waddr[p]] = wdata[p];
            end
        end
    endtask

    task automatic compare_outputs();
        logic trap_exp;
        trap_exp = (m_state == pipe_pkg::ST_TRAP);
        for (int l = 0; l < pipe_pkg::NUM_LANES; l++) begin
            check(32'(o_valid[l]), 32'(e_valid[l]), $sformatf("lane %0d valid", l));
            check(32'(o_uop[l]), 32'(e_uop[l]), $sformatf("lane %0d uop", l));
            check(o_imm[l], e_imm[l], $sformatf("lane %0d imm", l));
            check(32'({o_rj[l], o_rk[l], o_rd[l]}), 32'({e_rj[l], e_rk[l], e_rd[l]}),
                  $sformatf("lane %0d register numbers", l));
            check(32'({o_sys[l], o_brk[l], o_priv[l]}), 32'({e_sys[l], e_brk[l], e_priv[l]}),
                  $sformatf("lane %0d flags", l));
            check(o_rj_data[l], e_rj_data[l], $sformatf("lane %0d rj operand", l));
            check(o_rk_data[l], e_rk_data[l], $sformatf("lane %0d rk operand", l));
        end
        check(32'({o_trap_valid, o_trap_cause, o_trap_lane, o_kill_lane1}),
              32'({trap_exp, m_cause, m_lane, trap_exp && !m_lane}),
              "trap valid, cause, lane, kill_lane1");
        if (o_trap_valid) begin
            traps++;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        compare_outputs();
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < cpu_isa_pkg::NUM_REGS; i++) begin
            m_regs[i] = '0;
        end
        for (int l = 0; l < pipe_pkg::NUM_LANES; l++) begin
            e_valid[l]   = 1'b0;
            e_uop[l]     = '0;
            e_imm[l]     = '0;
            e_rj[l]      = '0;
            e_rk[l]      = '0;
            e_rd[l]      = '0;
            e_sys[l]     = 1'b0;
            e_brk[l]     = 1'b0;
            e_priv[l]    = 1'b0;
            e_rj_data[l] = '0;
            e_rk_data[l] = '0;
        end
        m_state = pipe_pkg::ST_RUN;
        m_cause = cpu_isa_pkg::EXC_NONE;
        m_lane  = 1'b0;
        model_edge();
    endtask

    // four read ports walk all 32 registers.
    task automatic read_after_reset();
        int errs_before;
        errs_before = errors;
        for (int c = 0; c < READ_CYCLES; c++) begin
            step();
            valid[0] = 1'b1;
            valid[1] = 1'b1;
            rj[0]    = 5'(4 * c);
            rk[0]    = 5'(4 * c + 1);
            rj[1]    = 5'(4 * c + 2);
            rk[1]    = 5'(4 * c + 3);
            model_edge();
        end
        tests++;
        $display("reset state: %0d cycles, %0d errors", READ_CYCLES, errors - errs_before);
    endtask

    task automatic drive_random(input int flush_pct, input int flag_pct, input int addr_max);
        for (int l = 0; l < pipe_pkg::NUM_LANES; l++) begin
            valid[l] = 1'($urandom_range(0, 1));
            uop[l]   = 8'($urandom);
            imm[l]   = $urandom;
            rj[l]    = 5'($urandom_range(0, addr_max));
            rk[l]    = 5'($urandom_range(0, addr_max));
            rd[l]    = 5'($urandom);
            sys[l]   = ($urandom_range(0, 99) < flag_pct);
            brk[l]   = ($urandom_range(0, 99) < flag_pct);
            priv[l]  = ($urandom_range(0, 99) < flag_pct);
            we[l]    = 1'($urandom_range(0, 1));
            waddr[l] = 5'($urandom_range(0, addr_max));
            wdata[l] = $urandom;
        end
        flush    = ($urandom_range(0, 99) < flush_pct);
        redirect = ($urandom_range(0, 99) < 30);
    endtask

    task automatic run_random(input string name, input int cycles, input int flush_pct,
                              input int flag_pct, input int addr_max);
        int errs_before;
        errs_before = errors;
        repeat (cycles) begin
            step();
            drive_random(flush_pct, flag_pct, addr_max);
            model_edge();
        end
        tests++;
        $display("%s: %0d cycles, %0d errors", name, cycles, errors - errs_before);
    endtask

    initial begin
        void'($urandom(32'h519f));
        errors = 0;
        checks = 0;
        tests  = 0;
        traps  = 0;
        apply_reset();
        read_after_reset();
        // narrow address range forces forwarding and port collisions.
        run_random("operands", OPER_CYCLES, 0, 0, 7);
        run_random("pipeline fields", PIPE_CYCLES, 0, 0, 31);
        run_random("flush", FLUSH_CYCLES, 20, 0, 31);
        traps = 0;
        run_random("exceptions", TRAP_CYCLES, 10, 8, 15);
        if (traps == 0) begin
            errors++;
            $display("the exception test finished without a single trap report");
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(TIME_LIMIT);
        $display("timeout: the run did not finish within %0d time units", TIME_LIMIT);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* hdl/issue_ex1_top.sv */
module issue_ex1_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    valid0_i,
    input  logic                    valid1_i,
    input  cpu_isa_pkg::uop_t       uop0_i,
    input  cpu_isa_pkg::uop_t       uop1_i,
    input  cpu_isa_pkg::word_t      imm0_i,
    input  cpu_isa_pkg::word_t      imm1_i,
    input  cpu_isa_pkg::reg_addr_t  rj0_i,
    input  cpu_isa_pkg::reg_addr_t  rk0_i,
    input  cpu_isa_pkg::reg_addr_t  rd0_i,
    input  cpu_isa_pkg::reg_addr_t  rj1_i,
    input  cpu_isa_pkg::reg_addr_t  rk1_i,
    input  cpu_isa_pkg::reg_addr_t  rd1_i,
    input  logic                    syscall0_i,
    input  logic                    brk0_i,
    input  logic                    priv0_i,
    input  logic                    syscall1_i,
    input  logic                    brk1_i,
    input  logic                    priv1_i,
    input  logic                    we0_i,
    input  cpu_isa_pkg::reg_addr_t  waddr0_i,
    input  cpu_isa_pkg::word_t      wdata0_i,
    input  logic                    we1_i,
    input  cpu_isa_pkg::reg_addr_t  waddr1_i,
    input  cpu_isa_pkg::word_t      wdata1_i,
    input  logic                    flush_i,
    input  logic                    redirect_i,
    output logic                    ex1_valid0_o,
    output logic                    ex1_valid1_o,
    output cpu_isa_pkg::uop_t       ex1_uop0_o,
    output cpu_isa_pkg::uop_t       ex1_uop1_o,
    output cpu_isa_pkg::word_t      ex1_imm0_o,
    output cpu_isa_pkg::word_t      ex1_imm1_o,
    output cpu_isa_pkg::reg_addr_t  ex1_rj0_o,
    output cpu_isa_pkg::reg_addr_t  ex1_rk0_o,
    output cpu_isa_pkg::reg_addr_t  ex1_rd0_o,
    output cpu_isa_pkg::reg_addr_t  ex1_rj1_o,
    output cpu_isa_pkg::reg_addr_t  ex1_rk1_o,
    output cpu_isa_pkg::reg_addr_t  ex1_rd1_o,
    output logic                    ex1_syscall0_o,
    output logic                    ex1_brk0_o,
    output logic                    ex1_priv0_o,
    output logic                    ex1_syscall1_o,
    output logic                    ex1_brk1_o,
    output logic                    ex1_priv1_o,
    output cpu_isa_pkg::word_t      ex1_rj0_data_o,
    output cpu_isa_pkg::word_t      ex1_rj1_data_o,
    output cpu_isa_pkg::word_t      ex1_rk0_data_o,
    output cpu_isa_pkg::word_t      ex1_rk1_data_o,
    output logic                    trap_valid_o,
    output cpu_isa_pkg::exc_cause_t trap_cause_o,
    output logic                    trap_lane_o,
    output logic                    kill_lane1_o
);

    cpu_isa_pkg::word_t rj0_data;
    cpu_isa_pkg::word_t rk0_data;
    cpu_isa_pkg::word_t rj1_data;
    cpu_isa_pkg::word_t rk1_data;
    logic               ex1_kill;

    // read ports 0/1 serve lane 0, 2/3 serve lane 1.
    regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .we0_i    (we0_i),
        .waddr0_i (waddr0_i),
        .wdata0_i (wdata0_i),
        .we1_i    (we1_i),
        .waddr1_i (waddr1_i),
        .wdata1_i (wdata1_i),
        .raddr0_i (rj0_i),
        .raddr1_i (rk0_i),
        .raddr2_i (rj1_i),
        .raddr3_i (rk1_i),
        .rdata0_o (rj0_data),
        .rdata1_o (rk0_data),
        .rdata2_o (rj1_data),
        .rdata3_o (rk1_data)
    );

    reg_ex1 u_reg_ex1 (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .kill_i     (ex1_kill),
        .valid0_i   (valid0_i),
        .valid1_i   (valid1_i),
        .uop0_i     (uop0_i),
        .uop1_i     (uop1_i),
        .imm0_i     (imm0_i),
        .imm1_i     (imm1_i),
        .rj0_i      (rj0_i),
        .rk0_i      (rk0_i),
        .rd0_i      (rd0_i),
        .rj1_i      (rj1_i),
        .rk1_i      (rk1_i),
        .rd1_i      (rd1_i),
        .syscall0_i (syscall0_i),
        .brk0_i     (brk0_i),
        .priv0_i    (priv0_i),
        .syscall1_i (syscall1_i),
        .brk1_i     (brk1_i),
        .priv1_i    (priv1_i),
        .rj0_data_i (rj0_data),
        .rj1_data_i (rj1_data),
        .rk0_data_i (rk0_data),
        .rk1_data_i (rk1_data),
        .valid0_o   (ex1_valid0_o),
        .valid1_o   (ex1_valid1_o),
        .uop0_o     (ex1_uop0_o),
        .uop1_o     (ex1_uop1_o),
        .imm0_o     (ex1_imm0_o),
        .imm1_o     (ex1_imm1_o),
        .rj0_o      (ex1_rj0_o),
        .rk0_o      (ex1_rk0_o),
        .rd0_o      (ex1_rd0_o),
        .rj1_o      (ex1_rj1_o),
        .rk1_o      (ex1_rk1_o),
        .rd1_o      (ex1_rd1_o),
        .syscall0_o (ex1_syscall0_o),
        .brk0_o     (ex1_brk0_o),
        .priv0_o    (ex1_priv0_o),
        .syscall1_o (ex1_syscall1_o),
        .brk1_o     (ex1_brk1_o),
        .priv1_o    (ex1_priv1_o),
        .rj0_data_o (ex1_rj0_data_o),
        .rj1_data_o (ex1_rj1_data_o),
        .rk0_data_o (ex1_rk0_data_o),
        .rk1_data_o (ex1_rk1_data_o)
    );

    // watches the latch outputs, not the issue inputs.
    exc_ctrl u_exc_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect_i),
        .valid0_i     (ex1_valid0_o),
        .valid1_i     (ex1_valid1_o),
        .syscall0_i   (ex1_syscall0_o),
        .brk0_i       (ex1_brk0_o),
        .priv0_i      (ex1_priv0_o),
        .syscall1_i   (ex1_syscall1_o),
        .brk1_i       (ex1_brk1_o),
        .priv1_i      (ex1_priv1_o),
        .kill_o       (ex1_kill),
        .trap_valid_o (trap_valid_o),
        .trap_cause_o (trap_cause_o),
        .trap_lane_o  (trap_lane_o),
        .kill_lane1_o (kill_lane1_o)
    );

endmodule

/* hdl/exc_ctrl.sv */
module exc_ctrl (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    redirect_i,
    input  logic                    valid0_i,
    input  logic                    valid1_i,
    input  logic                    syscall0_i,
    input  logic                    brk0_i,
    input  logic                    priv0_i,
    input  logic                    syscall1_i,
    input  logic                    brk1_i,
    input  logic                    priv1_i,
    output logic                    kill_o,
    output logic                    trap_valid_o,
    output cpu_isa_pkg::exc_cause_t trap_cause_o,
    output logic                    trap_lane_o,
    output logic                    kill_lane1_o
);

    pipe_pkg::exc_state_t state_q;

    logic [pipe_pkg::NUM_LANES-1:0] lane_valid;
    logic [pipe_pkg::NUM_LANES-1:0] lane_sys;
    logic [pipe_pkg::NUM_LANES-1:0] lane_brk;
    logic [pipe_pkg::NUM_LANES-1:0] lane_priv;

    logic                    hit;
    logic                    hit_lane;
    cpu_isa_pkg::exc_cause_t hit_cause;

    assign lane_valid = {valid1_i, valid0_i};
    assign lane_sys   = {syscall1_i, syscall0_i};
    assign lane_brk   = {brk1_i, brk0_i};
    assign lane_priv  = {priv1_i, priv0_i};

    // walk from youngest to oldest so the oldest flagged lane wins.
    always_comb begin
        hit       = 1'b0;
        hit_lane  = 1'b0;
        hit_cause = cpu_isa_pkg::EXC_NONE;
        for (int i = pipe_pkg::NUM_LANES - 1; i >= 0; i--) begin
            if (lane_valid[i] && (lane_sys[i] || lane_brk[i] || lane_priv[i])) begin
                hit      = 1'b1;
                hit_lane = 1'(i);
                if (lane_sys[i]) begin
                    hit_cause = cpu_isa_pkg::EXC_SYSCALL;
                end else if (lane_brk[i]) begin
                    hit_cause = cpu_isa_pkg::EXC_BREAK;
                end else begin
                    hit_cause = cpu_isa_pkg::EXC_PRIV;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q      <= pipe_pkg::ST_RUN;
            trap_cause_o <= cpu_isa_pkg::EXC_NONE;
            trap_lane_o  <= 1'b0;
        end else begin
            case (state_q)
                pipe_pkg::ST_RUN: begin
                    if (hit) begin
                        state_q      <= pipe_pkg::ST_TRAP;
                        trap_cause_o <= hit_cause;
                        trap_lane_o  <= hit_lane;
                    end
                end
                pipe_pkg::ST_TRAP: begin
                    state_q <= pipe_pkg::ST_DRAIN;
                end
                pipe_pkg::ST_DRAIN: begin
                    if (redirect_i) begin
                        state_q <= pipe_pkg::ST_RUN;
                    end
                end
                default: begin
                    state_q <= pipe_pkg::ST_RUN;
                end
            endcase
        end
    end

    // latch stays empty from the report until the redirect.
    assign kill_o       = (state_q != pipe_pkg::ST_RUN);
    assign trap_valid_o = (state_q == pipe_pkg::ST_TRAP);
    assign kill_lane1_o = trap_valid_o && !trap_lane_o;

endmodule

/* hdl/reg_ex1.sv */
module reg_ex1 (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   kill_i,
    input  logic                   valid0_i,
    input  logic                   valid1_i,
    input  cpu_isa_pkg::uop_t      uop0_i,
    input  cpu_isa_pkg::uop_t      uop1_i,
    input  cpu_isa_pkg::word_t     imm0_i,
    input  cpu_isa_pkg::word_t     imm1_i,
    input  cpu_isa_pkg::reg_addr_t rj0_i,
    input  cpu_isa_pkg::reg_addr_t rk0_i,
    input  cpu_isa_pkg::reg_addr_t rd0_i,
    input  cpu_isa_pkg::reg_addr_t rj1_i,
    input  cpu_isa_pkg::reg_addr_t rk1_i,
    input  cpu_isa_pkg::reg_addr_t rd1_i,
    input  logic                   syscall0_i,
    input  logic                   brk0_i,
    input  logic                   priv0_i,
    input  logic                   syscall1_i,
    input  logic                   brk1_i,
    input  logic                   priv1_i,
    input  cpu_isa_pkg::word_t     rj0_data_i,
    input  cpu_isa_pkg::word_t     rj1_data_i,
    input  cpu_isa_pkg::word_t     rk0_data_i,
    input  cpu_isa_pkg::word_t     rk1_data_i,
    output logic                   valid0_o,
    output logic                   valid1_o,
    output cpu_isa_pkg::uop_t      uop0_o,
    output cpu_isa_pkg::uop_t      uop1_o,
    output cpu_isa_pkg::word_t     imm0_o,
    output cpu_isa_pkg::word_t     imm1_o,
    output cpu_isa_pkg::reg_addr_t rj0_o,
    output cpu_isa_pkg::reg_addr_t rk0_o,
    output cpu_isa_pkg::reg_addr_t rd0_o,
    output cpu_isa_pkg::reg_addr_t rj1_o,
    output cpu_isa_pkg::reg_addr_t rk1_o,
    output cpu_isa_pkg::reg_addr_t rd1_o,
    output logic                   syscall0_o,
    output logic                   brk0_o,
    output logic                   priv0_o,
    output logic                   syscall1_o,
    output logic                   brk1_o,
    output logic                   priv1_o,
    output cpu_isa_pkg::word_t     rj0_data_o,
    output cpu_isa_pkg::word_t     rj1_data_o,
    output cpu_isa_pkg::word_t     rk0_data_o,
    output cpu_isa_pkg::word_t     rk1_data_o
);

    // any of these turns the latch into an all-zero bubble.
    logic clear;

    assign clear = !rst_n_i || flush_i || kill_i;

    always_ff @(posedge clk) begin
        if (clear) begin
            valid0_o   <= 1'b0;
            valid1_o   <= 1'b0;
            uop0_o     <= '0;
            uop1_o     <= '0;
            imm0_o     <= '0;
            imm1_o     <= '0;
            rj0_o      <= '0;
            rk0_o      <= '0;
            rd0_o      <= '0;
            rj1_o      <= '0;
            rk1_o      <= '0;
            rd1_o      <= '0;
            syscall0_o <= 1'b0;
            brk0_o     <= 1'b0;
            priv0_o    <= 1'b0;
            syscall1_o <= 1'b0;
            brk1_o     <= 1'b0;
            priv1_o    <= 1'b0;
            rj0_data_o <= '0;
            rj1_data_o <= '0;
            rk0_data_o <= '0;
            rk1_data_o <= '0;
        end else begin
            valid0_o   <= valid0_i;
            valid1_o   <= valid1_i;
            uop0_o     <= uop0_i;
            uop1_o     <= uop1_i;
            imm0_o     <= imm0_i;
            imm1_o     <= imm1_i;
            rj0_o      <= rj0_i;
            rk0_o      <= rk0_i;
            rd0_o      <= rd0_i;
            rj1_o      <= rj1_i;
            rk1_o      <= rk1_i;
            rd1_o      <= rd1_i;
            syscall0_o <= syscall0_i;
            brk0_o     <= brk0_i;
            priv0_o    <= priv0_i;
            syscall1_o <= syscall1_i;
            brk1_o     <= brk1_i;
            priv1_o    <= priv1_i;
            // operands already carry same-cycle forwarding.
            rj0_data_o <= rj0_data_i;
            rj1_data_o <= rj1_data_i;
            rk0_data_o <= rk0_data_i;
            rk1_data_o <= rk1_data_i;
        end
    end

endmodule

/* hdl/regfile.sv */
module regfile (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   we0_i,
    input  cpu_isa_pkg::reg_addr_t waddr0_i,
    input  cpu_isa_pkg::word_t     wdata0_i,
    input  logic                   we1_i,
    input  cpu_isa_pkg::reg_addr_t waddr1_i,
    input  cpu_isa_pkg::word_t     wdata1_i,
    input  cpu_isa_pkg::reg_addr_t raddr0_i,
    input  cpu_isa_pkg::reg_addr_t raddr1_i,
    input  cpu_isa_pkg::reg_addr_t raddr2_i,
    input  cpu_isa_pkg::reg_addr_t raddr3_i,
    output cpu_isa_pkg::word_t     rdata0_o,
    output cpu_isa_pkg::word_t     rdata1_o,
    output cpu_isa_pkg::word_t     rdata2_o,
    output cpu_isa_pkg::word_t     rdata3_o
);

    cpu_isa_pkg::word_t mem [cpu_isa_pkg::NUM_REGS];

    // one write port per lane, higher index is younger.
    logic [pipe_pkg::NUM_LANES-1:0] we;
    cpu_isa_pkg::reg_addr_t         waddr [pipe_pkg::NUM_LANES];
    cpu_isa_pkg::word_t             wdata [pipe_pkg::NUM_LANES];

    // two source operands per lane.
    cpu_isa_pkg::reg_addr_t         raddr [2*pipe_pkg::NUM_LANES];
    cpu_isa_pkg::word_t             rdata [2*pipe_pkg::NUM_LANES];

    assign we       = {we1_i, we0_i};
    assign waddr[0] = waddr0_i;
    assign waddr[1] = waddr1_i;
    assign wdata[0] = wdata0_i;
    assign wdata[1] = wdata1_i;

    assign raddr[0] = raddr0_i;
    assign raddr[1] = raddr1_i;
    assign raddr[2] = raddr2_i;
    assign raddr[3] = raddr3_i;

    // later port overrides, so port 1 wins on equal addresses.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < cpu_isa_pkg::NUM_REGS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int p = 0; p < pipe_pkg::NUM_LANES; p++) begin
                if (we[p] && (waddr[p] != '0)) begin
                    mem[waddr[p]] <= wdata[p];
                end
            end
        end
    end

    // same-cycle forwarding, younger write port takes precedence.
    always_comb begin
        for (int r = 0; r < 2*pipe_pkg::NUM_LANES; r++) begin
            rdata[r] = mem[raddr[r]];
            for (int p = 0; p < pipe_pkg::NUM_LANES; p++) begin
                if (we[p] && (waddr[p] == raddr[r])) begin
                    rdata[r] = wdata[p];
                end
            end
            if (raddr[r] == '0) begin
                rdata[r] = '0;
            end
        end
    end

    assign rdata0_o = rdata[0];
    assign rdata1_o = rdata[1];
    assign rdata2_o = rdata[2];
    assign rdata3_o = rdata[3];

endmodule

/* hdl/pipe_pkg.sv */
package pipe_pkg;

    // issue width, lane 0 holds the older slot.
    localparam int NUM_LANES = 2;

    // exception controller states.
    // run: latch captures normally.
    // trap: one-cycle trap report, latch killed.
    // drain: latch held empty until the front end redirects.
    typedef enum logic [1:0] {
        ST_RUN   = 2'd0,
        ST_TRAP  = 2'd1,
        ST_DRAIN = 2'd2
    } exc_state_t;

endpackage

/* hdl/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    // micro-op code width.
    localparam int UOP_W = 8;

    // architectural register count, r0 is hardwired to zero.
    localparam int NUM_REGS = 32;

    // register values and immediates.
    typedef logic [31:0] word_t;

    // architectural register number.
    typedef logic [4:0] reg_addr_t;

    // zero means no operation.
    typedef logic [UOP_W-1:0] uop_t;

    // trap causes reported by the exception controller.
    typedef enum logic [1:0] {
        EXC_NONE    = 2'd0,
        EXC_SYSCALL = 2'd1,
        EXC_BREAK   = 2'd2,
        EXC_PRIV    = 2'd3
    } exc_cause_t;

endpackage
